//--- ar_decode.sv
`default_nettype none

module ar_decode (
	input  wire                                  ACLK,
	input  wire                                  ARESETn,
	// Master 0
	input  wire  [axi_bus_pkg::AXI_ID_BITS-1:0]   arid_m0,
	input  wire  [axi_bus_pkg::AXI_ADDR_BITS-1:0] araddr_m0,
	input  wire  [axi_bus_pkg::AXI_LEN_BITS-1:0]  arlen_m0,
	input  wire                                  arvalid_m0,
	output logic                                 arready_m0,
	// Master 1
	input  wire  [axi_bus_pkg::AXI_ID_BITS-1:0]   arid_m1,
	input  wire  [axi_bus_pkg::AXI_ADDR_BITS-1:0] araddr_m1,
	input  wire  [axi_bus_pkg::AXI_LEN_BITS-1:0]  arlen_m1,
	input  wire                                  arvalid_m1,
	output logic                                 arready_m1,
	// Slave 0
	output logic [axi_bus_pkg::AXI_IDS_BITS-1:0]  arid_s0,
	output logic [axi_bus_pkg::AXI_ADDR_BITS-1:0] araddr_s0,
	output logic [axi_bus_pkg::AXI_LEN_BITS-1:0]  arlen_s0,
	output logic                                 arvalid_s0,
	input  wire                                  arready_s0,
	// Slave 1
	output logic [axi_bus_pkg::AXI_IDS_BITS-1:0]  arid_s1,
	output logic [axi_bus_pkg::AXI_ADDR_BITS-1:0] araddr_s1,
	output logic [axi_bus_pkg::AXI_LEN_BITS-1:0]  arlen_s1,
	output logic                                 arvalid_s1,
	input  wire                                  arready_s1,
	// Default slave
	output logic [axi_bus_pkg::AXI_IDS_BITS-1:0]  arid_sd,
	output logic [axi_bus_pkg::AXI_ADDR_BITS-1:0] araddr_sd,
	output logic [axi_bus_pkg::AXI_LEN_BITS-1:0]  arlen_sd,
	output logic                                 arvalid_sd,
	input  wire                                  arready_sd,
	// Last beat accepted by each master
	input  wire                                  done_m0,
	input  wire                                  done_m1
);

	import axi_bus_pkg::*;
	import axi_map_pkg::*;

	typedef enum logic {
		AR_IDLE,
		AR_ISSUE
	} ar_state_e;

	ar_state_e  state;
	slave_sel_e sel;
	logic       gnt_m1;
	logic       prio_m1;
	logic       busy_m0;
	logic       busy_m1;

	logic                     req_m0;
	logic                     req_m1;
	logic                     pick_m1;
	logic [AXI_ADDR_BITS-1:0] req_addr;
	logic [AXI_ID_BITS-1:0]   cur_id;
	logic [AXI_ADDR_BITS-1:0] cur_addr;
	logic [AXI_LEN_BITS-1:0]  cur_len;
	logic [TAG_BITS-1:0]      cur_tag;
	logic                     cur_valid;
	logic                     cur_ready;
	logic                     ar_hs;

	// ========================================
	// Arbitration
	// ========================================
	assign req_m0   = arvalid_m0 & ~busy_m0;
	assign req_m1   = arvalid_m1 & ~busy_m1;
	// M1 wins when alone, or on a tie when it holds priority
	assign pick_m1  = req_m1 & (~req_m0 | prio_m1);
	assign req_addr = pick_m1 ? araddr_m1 : araddr_m0;

	// Granted request presented straight from the master
	assign cur_id    = gnt_m1 ? arid_m1 : arid_m0;
	assign cur_addr  = gnt_m1 ? araddr_m1 : araddr_m0;
	assign cur_len   = gnt_m1 ? arlen_m1 : arlen_m0;
	assign cur_tag   = gnt_m1 ? TAG_M1 : TAG_M0;
	assign cur_valid = (state == AR_ISSUE) & (gnt_m1 ? arvalid_m1 : arvalid_m0);

	always_comb begin
		case (sel)
			SEL_S0:  cur_ready = arready_s0;
			SEL_S1:  cur_ready = arready_s1;
			default: cur_ready = arready_sd;
		endcase
	end

	assign ar_hs = cur_valid & cur_ready;

	// ========================================
	// Slave and master outputs
	// ========================================
	assign arid_s0    = {cur_tag, cur_id};
	assign arid_s1    = {cur_tag, cur_id};
	assign arid_sd    = {cur_tag, cur_id};
	assign araddr_s0  = cur_addr;
	assign araddr_s1  = cur_addr;
	assign araddr_sd  = cur_addr;
	assign arlen_s0   = cur_len;
	assign arlen_s1   = cur_len;
	assign arlen_sd   = cur_len;
	assign arvalid_s0 = cur_valid & (sel == SEL_S0);
	assign arvalid_s1 = cur_valid & (sel == SEL_S1);
	assign arvalid_sd = cur_valid & (sel == SEL_SD);

	assign arready_m0 = (state == AR_ISSUE) & ~gnt_m1 & cur_ready;
	assign arready_m1 = (state == AR_ISSUE) & gnt_m1 & cur_ready;

	// Grant FSM
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state   <= AR_IDLE;
			sel     <= SEL_S0;
			gnt_m1  <= 1'b0;
			prio_m1 <= 1'b0;
		end else begin
			case (state)
				AR_IDLE: begin
					if (req_m0 | req_m1) begin
						state   <= AR_ISSUE;
						gnt_m1  <= pick_m1;
						prio_m1 <= ~pick_m1;
						sel     <= decode_addr(req_addr);
					end
				end
				default: begin
					if (ar_hs) begin
						state <= AR_IDLE;
					end
				end
			endcase
		end
	end

	// One read outstanding per master
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			busy_m0 <= 1'b0;
			busy_m1 <= 1'b0;
		end else begin
			if (done_m0) begin
				busy_m0 <= 1'b0;
			end
			if (done_m1) begin
				busy_m1 <= 1'b0;
			end
			// Only the granted master turns busy
			if (ar_hs) begin
				if (gnt_m1) begin
					busy_m1 <= 1'b1;
				end else begin
					busy_m0 <= 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- axi_bus_pkg.sv
`default_nettype none

package axi_bus_pkg;

	// ========================================
	// Bus widths
	// ========================================
	localparam int AXI_ADDR_BITS = 32;
	localparam int AXI_DATA_BITS = 32;
	localparam int AXI_ID_BITS   = 4;
	localparam int AXI_IDS_BITS  = 8;
	localparam int AXI_LEN_BITS  = 4;

	// Upper nibble of a slave ID names the issuing master
	localparam int TAG_BITS = AXI_IDS_BITS - AXI_ID_BITS;

	localparam logic [TAG_BITS-1:0] TAG_M0 = TAG_BITS'(1);
	localparam logic [TAG_BITS-1:0] TAG_M1 = TAG_BITS'(2);

	// ========================================
	// Response codes
	// ========================================
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} resp_e;

endpackage

`default_nettype wire

//--- axi_map_pkg.sv
`default_nettype none

package axi_map_pkg;

	// Fixed map, 64 KiB per external slave
	localparam logic [axi_bus_pkg::AXI_ADDR_BITS-1:0] S0_BASE = 32'h0000_0000;
	localparam logic [axi_bus_pkg::AXI_ADDR_BITS-1:0] S0_LAST = 32'h0000_FFFF;
	localparam logic [axi_bus_pkg::AXI_ADDR_BITS-1:0] S1_BASE = 32'h0001_0000;
	localparam logic [axi_bus_pkg::AXI_ADDR_BITS-1:0] S1_LAST = 32'h0001_FFFF;

	typedef enum logic [1:0] {
		SEL_S0,
		SEL_S1,
		SEL_SD
	} slave_sel_e;

	// Region hit when the offset from its base is within its size
	function automatic slave_sel_e decode_addr(
		input logic [axi_bus_pkg::AXI_ADDR_BITS-1:0] addr
	);
		if ((addr - S0_BASE) <= (S0_LAST - S0_BASE)) begin
			return SEL_S0;
		end
		if ((addr - S1_BASE) <= (S1_LAST - S1_BASE)) begin
			return SEL_S1;
		end
		return SEL_SD;
	endfunction

endpackage

`default_nettype wire

//--- axi_read_bridge.sv
`default_nettype none

module axi_read_bridge #(
	parameter int DATA_W = axi_bus_pkg::AXI_DATA_BITS
) (
	input  wire                                  ACLK,
	input  wire                                  ARESETn,
	// Master 0
	input  wire  [axi_bus_pkg::AXI_ID_BITS-1:0]   arid_m0,
	input  wire  [axi_bus_pkg::AXI_ADDR_BITS-1:0] araddr_m0,
	input  wire  [axi_bus_pkg::AXI_LEN_BITS-1:0]  arlen_m0,
	input  wire                                  arvalid_m0,
	output logic                                 arready_m0,
	output logic [axi_bus_pkg::AXI_ID_BITS-1:0]   rid_m0,
	output logic [DATA_W-1:0]                    rdata_m0,
	output logic [1:0]                           rresp_m0,
	output logic                                 rlast_m0,
	output logic                                 rvalid_m0,
	input  wire                                  rready_m0,
	// Master 1
	input  wire  [axi_bus_pkg::AXI_ID_BITS-1:0]   arid_m1,
	input  wire  [axi_bus_pkg::AXI_ADDR_BITS-1:0] araddr_m1,
	input  wire  [axi_bus_pkg::AXI_LEN_BITS-1:0]  arlen_m1,
	input  wire                                  arvalid_m1,
	output logic                                 arready_m1,
	output logic [axi_bus_pkg::AXI_ID_BITS-1:0]   rid_m1,
	output logic [DATA_W-1:0]                    rdata_m1,
	output logic [1:0]                           rresp_m1,
	output logic                                 rlast_m1,
	output logic                                 rvalid_m1,
	input  wire                                  rready_m1,
	// Slave 0
	output logic [axi_bus_pkg::AXI_IDS_BITS-1:0]  arid_s0,
	output logic [axi_bus_pkg::AXI_ADDR_BITS-1:0] araddr_s0,
	output logic [axi_bus_pkg::AXI_LEN_BITS-1:0]  arlen_s0,
	output logic                                 arvalid_s0,
	input  wire                                  arready_s0,
	input  wire  [axi_bus_pkg::AXI_IDS_BITS-1:0]  rid_s0,
	input  wire  [DATA_W-1:0]                    rdata_s0,
	input  wire  [1:0]                           rresp_s0,
	input  wire                                  rlast_s0,
	input  wire                                  rvalid_s0,
	output logic                                 rready_s0,
	// Slave 1
	output logic [axi_bus_pkg::AXI_IDS_BITS-1:0]  arid_s1,
	output logic [axi_bus_pkg::AXI_ADDR_BITS-1:0] araddr_s1,
	output logic [axi_bus_pkg::AXI_LEN_BITS-1:0]  arlen_s1,
	output logic                                 arvalid_s1,
	input  wire                                  arready_s1,
	input  wire  [axi_bus_pkg::AXI_IDS_BITS-1:0]  rid_s1,
	input  wire  [DATA_W-1:0]                    rdata_s1,
	input  wire  [1:0]                           rresp_s1,
	input  wire                                  rlast_s1,
	input  wire                                  rvalid_s1,
	output logic                                 rready_s1
);

	import axi_bus_pkg::*;

	// ========================================
	// Default slave port and completion pulses
	// ========================================
	logic [AXI_IDS_BITS-1:0]  arid_sd;
	logic [AXI_ADDR_BITS-1:0] araddr_sd;
	logic [AXI_LEN_BITS-1:0]  arlen_sd;
	logic                     arvalid_sd;
	logic                     arready_sd;
	logic [AXI_IDS_BITS-1:0]  rid_sd;
	logic [DATA_W-1:0]        rdata_sd;
	logic [1:0]               rresp_sd;
	logic                     rlast_sd;
	logic                     rvalid_sd;
	logic                     rready_sd;
	logic                     done_m0;
	logic                     done_m1;

	// Port names line up with the nets here
	ar_decode u_ar_decode (.*);

	r_channel #(
		.DATA_W(DATA_W)
	) u_r_channel (.*);

	default_slave #(
		.DATA_W(DATA_W)
	) u_default_slave (
		.ACLK    (ACLK),
		.ARESETn (ARESETn),
		.arid    (arid_sd),
		.araddr  (araddr_sd),
		.arlen   (arlen_sd),
		.arvalid (arvalid_sd),
		.arready (arready_sd),
		.rid     (rid_sd),
		.rdata   (rdata_sd),
		.rresp   (rresp_sd),
		.rlast   (rlast_sd),
		.rvalid  (rvalid_sd),
		.rready  (rready_sd)
	);

endmodule

`default_nettype wire

//--- default_slave.sv
`default_nettype none

module default_slave #(
	parameter int DATA_W = axi_bus_pkg::AXI_DATA_BITS
) (
	input  wire                                  ACLK,
	input  wire                                  ARESETn,
	input  wire  [axi_bus_pkg::AXI_IDS_BITS-1:0]  arid,
	input  wire  [axi_bus_pkg::AXI_ADDR_BITS-1:0] araddr,
	input  wire  [axi_bus_pkg::AXI_LEN_BITS-1:0]  arlen,
	input  wire                                  arvalid,
	output logic                                 arready,
	output logic [axi_bus_pkg::AXI_IDS_BITS-1:0]  rid,
	output logic [DATA_W-1:0]                    rdata,
	output logic [1:0]                           rresp,
	output logic                                 rlast,
	output logic                                 rvalid,
	input  wire                                  rready
);

	import axi_bus_pkg::*;

	typedef enum logic {
		DS_IDLE,
		DS_RESP
	} ds_state_e;

	ds_state_e               state;
	logic [AXI_LEN_BITS-1:0] cnt;
	logic [AXI_LEN_BITS-1:0] len_q;
	logic [AXI_IDS_BITS-1:0] id_q;

	// Address content is irrelevant, every beat is a decode error
	assign arready = (state == DS_IDLE);
	assign rvalid  = (state == DS_RESP);
	assign rid     = id_q;
	assign rdata   = '0;
	assign rresp   = DECERR;
	assign rlast   = (state == DS_RESP) & (cnt == len_q);

	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			state <= DS_IDLE;
			cnt   <= '0;
		end else if (state == DS_IDLE) begin
			if (arvalid) begin
				state <= DS_RESP;
				cnt   <= '0;
			end
		end else if (rready) begin
			// One beat per handshake, back to idle after the last
			if (cnt == len_q) begin
				state <= DS_IDLE;
			end
			cnt <= cnt + 1'b1;
		end
	end

	// Request fields captured on acceptance
	always_ff @(posedge ACLK) begin
		if (arvalid && arready) begin
			id_q  <= arid;
			len_q <= arlen;
		end
	end

endmodule

`default_nettype wire

//--- filelist.f
axi_bus_pkg.sv
axi_map_pkg.sv
ar_decode.sv
r_channel.sv
default_slave.sv
axi_read_bridge.sv
tb_mem_slave.sv
tb_axi_read_bridge.sv

//--- r_channel.sv
`default_nettype none

module r_channel #(
	parameter int DATA_W = axi_bus_pkg::AXI_DATA_BITS
) (
	input  wire                                  ACLK,
	input  wire                                  ARESETn,
	// Slave 0
	input  wire  [axi_bus_pkg::AXI_IDS_BITS-1:0]  rid_s0,
	input  wire  [DATA_W-1:0]                    rdata_s0,
	input  wire  [1:0]                           rresp_s0,
	input  wire                                  rlast_s0,
	input  wire                                  rvalid_s0,
	output logic                                 rready_s0,
	// Slave 1
	input  wire  [axi_bus_pkg::AXI_IDS_BITS-1:0]  rid_s1,
	input  wire  [DATA_W-1:0]                    rdata_s1,
	input  wire  [1:0]                           rresp_s1,
	input  wire                                  rlast_s1,
	input  wire                                  rvalid_s1,
	output logic                                 rready_s1,
	// Default slave
	input  wire  [axi_bus_pkg::AXI_IDS_BITS-1:0]  rid_sd,
	input  wire  [DATA_W-1:0]                    rdata_sd,
	input  wire  [1:0]                           rresp_sd,
	input  wire                                  rlast_sd,
	input  wire                                  rvalid_sd,
	output logic                                 rready_sd,
	// Master 0
	output logic [axi_bus_pkg::AXI_ID_BITS-1:0]   rid_m0,
	output logic [DATA_W-1:0]                    rdata_m0,
	output logic [1:0]                           rresp_m0,
	output logic                                 rlast_m0,
	output logic                                 rvalid_m0,
	input  wire                                  rready_m0,
	// Master 1
	output logic [axi_bus_pkg::AXI_ID_BITS-1:0]   rid_m1,
	output logic [DATA_W-1:0]                    rdata_m1,
	output logic [1:0]                           rresp_m1,
	output logic                                 rlast_m1,
	output logic                                 rvalid_m1,
	input  wire                                  rready_m1,
	output logic                                 done_m0,
	output logic                                 done_m1
);

	import axi_bus_pkg::*;

	typedef enum logic {
		LK_FREE,
		LK_HELD
	} lock_e;

	lock_e      lock;
	logic [1:0] lock_idx;
	logic [1:0] last_idx;

	// Slave index 0 = S0, 1 = S1, 2 = default slave
	logic [2:0]              vld;
	logic [2:0]              last_a;
	logic [AXI_IDS_BITS-1:0] id_a   [3];
	logic [DATA_W-1:0]       data_a [3];
	logic [1:0]              resp_a [3];

	logic [1:0]              pick;
	logic                    found;
	logic [1:0]              cur;
	logic                    s_valid;
	logic [AXI_IDS_BITS-1:0] s_id;
	logic                    to_m0;
	logic                    to_m1;
	logic                    fwd_ready;
	logic                    hs;

	function automatic logic [1:0] next_idx(input logic [1:0] idx);
		return (idx == 2'd2) ? 2'd0 : idx + 2'd1;
	endfunction

	assign vld    = {rvalid_sd, rvalid_s1, rvalid_s0};
	assign last_a = {rlast_sd, rlast_s1, rlast_s0};
	assign id_a   = '{rid_s0, rid_s1, rid_sd};
	assign data_a = '{rdata_s0, rdata_s1, rdata_sd};
	assign resp_a = '{rresp_s0, rresp_s1, rresp_sd};

	// ========================================
	// Rotating pick, search starts after last served
	// ========================================
	always_comb begin
		logic [1:0] cand;
		cand  = last_idx;
		pick  = last_idx;
		found = 1'b0;
		for (int k = 0; k < 3; k++) begin
			cand = next_idx(cand);
			if (!found && vld[cand]) begin
				pick  = cand;
				found = 1'b1;
			end
		end
	end

	// Locked slave keeps the path even across gaps in its burst
	assign cur     = (lock == LK_HELD) ? lock_idx : pick;
	assign s_valid = ((lock == LK_HELD) | found) & vld[cur];
	assign s_id    = id_a[cur];
	assign to_m0   = s_id[AXI_IDS_BITS-1:AXI_ID_BITS] == TAG_M0;
	assign to_m1   = s_id[AXI_IDS_BITS-1:AXI_ID_BITS] == TAG_M1;

	// Tag stripped, payload shared, valid only toward the tagged master
	assign rid_m0    = s_id[AXI_ID_BITS-1:0];
	assign rid_m1    = s_id[AXI_ID_BITS-1:0];
	assign rdata_m0  = data_a[cur];
	assign rdata_m1  = data_a[cur];
	assign rresp_m0  = resp_a[cur];
	assign rresp_m1  = resp_a[cur];
	assign rlast_m0  = last_a[cur];
	assign rlast_m1  = last_a[cur];
	assign rvalid_m0 = s_valid & to_m0;
	assign rvalid_m1 = s_valid & to_m1;

	assign fwd_ready = s_valid & ((to_m0 & rready_m0) | (to_m1 & rready_m1));
	assign rready_s0 = fwd_ready & (cur == 2'd0);
	assign rready_s1 = fwd_ready & (cur == 2'd1);
	assign rready_sd = fwd_ready & (cur == 2'd2);

	assign hs      = fwd_ready;
	assign done_m0 = hs & last_a[cur] & to_m0;
	assign done_m1 = hs & last_a[cur] & to_m1;

	// Burst lock
	always_ff @(posedge ACLK) begin
		if (!ARESETn) begin
			lock     <= LK_FREE;
			lock_idx <= 2'd0;
			last_idx <= 2'd2;
		end else if (hs && last_a[cur]) begin
			lock     <= LK_FREE;
			last_idx <= cur;
		end else if (lock == LK_FREE && s_valid) begin
			lock     <= LK_HELD;
			lock_idx <= cur;
		end
	end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the read bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -j 0 --top-module tb_axi_read_bridge \
	--Mdir "$OBJ" -f filelist.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/Vtb_axi_read_bridge" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
	echo "Simulation reported failures"
	exit 1
fi

exit 0

//--- tb_axi_read_bridge.sv
`default_nettype none

module tb_axi_read_bridge;

	import axi_bus_pkg::*;
	import axi_map_pkg::*;

	localparam int                DATA_W  = AXI_DATA_BITS;
	localparam logic [DATA_W-1:0] S0_KEY  = DATA_W'(32'h5A5A_0F0F);
	localparam logic [DATA_W-1:0] S1_KEY  = DATA_W'(32'hC3C3_7E7E);
	localparam int                TIMEOUT = 2000;

	typedef struct packed {
		logic [AXI_ID_BITS-1:0] id;
		logic [1:0]             resp;
		logic                   last;
		logic [DATA_W-1:0]      data;
	} beat_t;

	logic                     ACLK;
	logic                     ARESETn;
	// Master ports
	logic [AXI_ID_BITS-1:0]   arid_m0;
	logic [AXI_ADDR_BITS-1:0] araddr_m0;
	logic [AXI_LEN_BITS-1:0]  arlen_m0;
	logic                     arvalid_m0;
	logic                     arready_m0;
	logic [AXI_ID_BITS-1:0]   rid_m0;
	logic [DATA_W-1:0]        rdata_m0;
	logic [1:0]               rresp_m0;
	logic                     rlast_m0;
	logic                     rvalid_m0;
	logic                     rready_m0;
	logic [AXI_ID_BITS-1:0]   arid_m1;
	logic [AXI_ADDR_BITS-1:0] araddr_m1;
	logic [AXI_LEN_BITS-1:0]  arlen_m1;
	logic                     arvalid_m1;
	logic                     arready_m1;
	logic [AXI_ID_BITS-1:0]   rid_m1;
	logic [DATA_W-1:0]        rdata_m1;
	logic [1:0]               rresp_m1;
	logic                     rlast_m1;
	logic                     rvalid_m1;
	logic                     rready_m1;
	// Slave ports
	logic [AXI_IDS_BITS-1:0]  arid_s0;
	logic [AXI_ADDR_BITS-1:0] araddr_s0;
	logic [AXI_LEN_BITS-1:0]  arlen_s0;
	logic                     arvalid_s0;
	logic                     arready_s0;
	logic [AXI_IDS_BITS-1:0]  rid_s0;
	logic [DATA_W-1:0]        rdata_s0;
	logic [1:0]               rresp_s0;
	logic                     rlast_s0;
	logic                     rvalid_s0;
	logic                     rready_s0;
	logic                     stuck_s0;
	logic [AXI_IDS_BITS-1:0]  arid_s1;
	logic [AXI_ADDR_BITS-1:0] araddr_s1;
	logic [AXI_LEN_BITS-1:0]  arlen_s1;
	logic                     arvalid_s1;
	logic                     arready_s1;
	logic [AXI_IDS_BITS-1:0]  rid_s1;
	logic [DATA_W-1:0]        rdata_s1;
	logic [1:0]               rresp_s1;
	logic                     rlast_s1;
	logic                     rvalid_s1;
	logic                     rready_s1;
	logic                     stuck_s1;

	// Expected beats per master in order of arrival
	beat_t exp_m0 [$];
	beat_t exp_m1 [$];
	int    issued_m0;
	int    issued_m1;
	int    done_cnt_m0;
	int    done_cnt_m1;
	int    errors;
	int    tests_run;
	int    tests_failed;
	logic  bp_mode;

	axi_read_bridge #(
		.DATA_W(DATA_W)
	) dut (.*);

	tb_mem_slave #(
		.DATA_W (DATA_W),
		.KEY    (S0_KEY)
	) mem_s0 (
		.ACLK    (ACLK),
		.ARESETn (ARESETn),
		.arid    (arid_s0),
		.araddr  (araddr_s0),
		.arlen   (arlen_s0),
		.arvalid (arvalid_s0),
		.arready (arready_s0),
		.rid     (rid_s0),
		.rdata   (rdata_s0),
		.rresp   (rresp_s0),
		.rlast   (rlast_s0),
		.rvalid  (rvalid_s0),
		.rready  (rready_s0),
		.stuck   (stuck_s0)
	);

	tb_mem_slave #(
		.DATA_W (DATA_W),
		.KEY    (S1_KEY)
	) mem_s1 (
		.ACLK    (ACLK),
		.ARESETn (ARESETn),
		.arid    (arid_s1),
		.araddr  (araddr_s1),
		.arlen   (arlen_s1),
		.arvalid (arvalid_s1),
		.arready (arready_s1),
		.rid     (rid_s1),
		.rdata   (rdata_s1),
		.rresp   (rresp_s1),
		.rlast   (rlast_s1),
		.rvalid  (rvalid_s1),
		.rready  (rready_s1),
		.stuck   (stuck_s1)
	);

	initial begin
		ACLK = 1'b0;
		forever begin
			#2 ACLK = ~ACLK;
		end
	end

	// ========================================
	// Reference model and checks
	// ========================================
	function automatic beat_t ref_beat(
		input logic [AXI_ADDR_BITS-1:0] addr,
		input int                       k,
		input logic [AXI_ID_BITS-1:0]   id,
		input logic [AXI_LEN_BITS-1:0]  len
	);
		beat_t                    b;
		logic [AXI_ADDR_BITS-1:0] a_k;
		a_k    = addr + AXI_ADDR_BITS'(4 * k);
		b.id   = id;
		b.last = (k == int'(len));
		if ((addr >= S0_BASE) && (addr <= S0_LAST)) begin
			b.resp = OKAY;
			b.data = DATA_W'(a_k) ^ S0_KEY;
		end else if ((addr >= S1_BASE) && (addr <= S1_LAST)) begin
			b.resp = OKAY;
			b.data = DATA_W'(a_k) ^ S1_KEY;
		end else begin
			b.resp = DECERR;
			b.data = '0;
		end
		return b;
	endfunction

	function automatic logic [AXI_ADDR_BITS-1:0] rand_addr(input int region);
		logic [AXI_ADDR_BITS-1:0] r;
		r = AXI_ADDR_BITS'($urandom) & 32'h0000_FFFC;
		if (region == 0) begin
			return S0_BASE | r;
		end
		if (region == 1) begin
			return S1_BASE | r;
		end
		// Bit 17 set lands above both mapped slaves
		return (AXI_ADDR_BITS'($urandom) & 32'hFFFF_FFFC) | 32'h0002_0000;
	endfunction

	task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t %s: got %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic take_beat(
		input int                     m,
		input logic [AXI_ID_BITS-1:0] id,
		input logic [DATA_W-1:0]      data,
		input logic [1:0]             resp,
		input logic                   last
	);
		beat_t e;
		if (last) begin
			if (m == 0) done_cnt_m0++;
			else done_cnt_m1++;
		end
		if ((m == 0 ? exp_m0.size() : exp_m1.size()) == 0) begin
			errors++;
			$display("Master %0d received a beat at time %0t that no read asked for", m, $time);
		end else begin
			if (m == 0) e = exp_m0.pop_front();
			else e = exp_m1.pop_front();
			check_value($sformatf("m%0d rid", m), 64'(id), 64'(e.id));
			check_value($sformatf("m%0d rdata", m), 64'(data), 64'(e.data));
			check_value($sformatf("m%0d rresp", m), 64'(resp), 64'(e.resp));
			check_value($sformatf("m%0d rlast", m), 64'(last), 64'(e.last));
		end
	endtask

	// R channel monitor for each master
	initial begin
		rready_m0 = 1'b0;
		forever begin
			@(negedge ACLK);
			rready_m0 = bp_mode ? ($urandom_range(3, 0) != 0) : 1'b1;
			#1;
			if (ARESETn && rvalid_m0 && rready_m0) begin
				take_beat(0, rid_m0, rdata_m0, rresp_m0, rlast_m0);
			end
		end
	end

	initial begin
		rready_m1 = 1'b0;
		forever begin
			@(negedge ACLK);
			rready_m1 = bp_mode ? ($urandom_range(3, 0) != 0) : 1'b1;
			#1;
			if (ARESETn && rvalid_m1 && rready_m1) begin
				take_beat(1, rid_m1, rdata_m1, rresp_m1, rlast_m1);
			end
		end
	end

	// ========================================
	// Master AR driver
	// ========================================
	task automatic issue_read(
		input int                       m,
		input logic [AXI_ID_BITS-1:0]   id,
		input logic [AXI_ADDR_BITS-1:0] addr,
		input logic [AXI_LEN_BITS-1:0]  len
	);
		int   cnt;
		logic rdy;
		@(negedge ACLK);
		if (m == 0) begin
			arid_m0    = id;
			araddr_m0  = addr;
			arlen_m0   = len;
			arvalid_m0 = 1'b1;
		end else begin
			arid_m1    = id;
			araddr_m1  = addr;
			arlen_m1   = len;
			arvalid_m1 = 1'b1;
		end
		cnt = 0;
		rdy = 1'b0;
		while (!rdy && cnt < TIMEOUT) begin
			#1;
			rdy = (m == 0) ? arready_m0 : arready_m1;
			// Every earlier burst must have ended before a new accept
			if (rdy) begin
				check_value($sformatf("m%0d bursts done at accept", m),
					64'(m == 0 ? done_cnt_m0 : done_cnt_m1),
					64'(m == 0 ? issued_m0 : issued_m1));
			end
			@(negedge ACLK);
			cnt++;
		end
		if (rdy) begin
			for (int k = 0; k <= int'(len); k++) begin
				if (m == 0) exp_m0.push_back(ref_beat(addr, k, id, len));
				else exp_m1.push_back(ref_beat(addr, k, id, len));
			end
			if (m == 0) issued_m0++;
			else issued_m1++;
		end else begin
			errors++;
			$display("Timed out waiting for master %0d arready at time %0t", m, $time);
		end
		if (m == 0) arvalid_m0 = 1'b0;
		else arvalid_m1 = 1'b0;
	endtask

	task automatic wait_drain(input string name);
		int cnt;
		cnt = 0;
		while ((exp_m0.size() != 0 || exp_m1.size() != 0) && cnt < TIMEOUT) begin
			@(negedge ACLK);
			cnt++;
		end
		if (exp_m0.size() != 0 || exp_m1.size() != 0) begin
			errors++;
			$display("Timed out in %s with %0d and %0d beats never delivered",
				name, exp_m0.size(), exp_m1.size());
		end
		// Idle gap so stray beats still show up in this test
		repeat (8) @(negedge ACLK);
	endtask

	task automatic end_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("Test %s passed", name);
		end else begin
			tests_failed++;
			$display("Test %s failed with %0d errors", name, errors - err_before);
		end
	endtask

	task automatic check_reset_outputs();
		check_value("m0 arready in reset", 64'(arready_m0), 64'd0);
		check_value("m1 arready in reset", 64'(arready_m1), 64'd0);
		check_value("m0 rvalid in reset", 64'(rvalid_m0), 64'd0);
		check_value("m1 rvalid in reset", 64'(rvalid_m1), 64'd0);
	endtask

	// ========================================
	// Test sequence
	// ========================================
	initial begin
		int e0;
		void'($urandom(44170));
		ARESETn      = 1'b0;
		arid_m0      = '0;
		araddr_m0    = '0;
		arlen_m0     = '0;
		arvalid_m0   = 1'b0;
		arid_m1      = '0;
		araddr_m1    = '0;
		arlen_m1     = '0;
		arvalid_m1   = 1'b0;
		bp_mode      = 1'b0;
		issued_m0    = 0;
		issued_m1    = 0;
		done_cnt_m0  = 0;
		done_cnt_m1  = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;

		// Reset outputs, released on the sixteenth falling edge
		e0 = errors;
		repeat (15) begin
			@(negedge ACLK);
			#1;
			check_reset_outputs();
		end
		@(negedge ACLK);
		ARESETn = 1'b1;
		repeat (2) begin
			#1;
			check_reset_outputs();
			@(negedge ACLK);
		end
		end_test("reset_outputs", e0);

		// Single beats from both slaves
		e0 = errors;
		for (int m = 0; m < 2; m++) begin
			for (int s = 0; s < 2; s++) begin
				repeat (3) issue_read(m, AXI_ID_BITS'($urandom), rand_addr(s), '0);
			end
		end
		wait_drain("single_reads");
		end_test("single_reads", e0);

		// Every burst length
		e0 = errors;
		for (int m = 0; m < 2; m++) begin
			for (int len = 0; len < 16; len++) begin
				issue_read(m, AXI_ID_BITS'($urandom), rand_addr(len % 2), AXI_LEN_BITS'(len));
			end
		end
		wait_drain("bursts");
		end_test("bursts", e0);

		// Unmapped addresses
		e0 = errors;
		for (int m = 0; m < 2; m++) begin
			repeat (4) issue_read(m, AXI_ID_BITS'($urandom), rand_addr(2), AXI_LEN_BITS'($urandom));
		end
		wait_drain("unmapped");
		end_test("unmapped", e0);

		// Both masters at once on one slave, then on split and random slaves
		e0 = errors;
		bp_mode = 1'b1;
		fork
			for (int n = 0; n < 12; n++) begin
				issue_read(0, AXI_ID_BITS'($urandom),
					rand_addr(n < 8 ? 0 : int'($urandom_range(2, 0))),
					AXI_LEN_BITS'($urandom));
			end
			for (int n = 0; n < 12; n++) begin
				issue_read(1, AXI_ID_BITS'($urandom),
					rand_addr(n < 4 ? 0 : (n < 8 ? 1 : int'($urandom_range(2, 0)))),
					AXI_LEN_BITS'($urandom));
			end
		join
		wait_drain("concurrent");
		end_test("concurrent", e0);

		// Second address while the first burst is still in flight
		e0 = errors;
		fork
			begin
				issue_read(0, AXI_ID_BITS'($urandom), rand_addr(0), 4'd15);
				issue_read(0, AXI_ID_BITS'($urandom), rand_addr(1), 4'd3);
			end
			begin
				issue_read(1, AXI_ID_BITS'($urandom), rand_addr(1), 4'd15);
				issue_read(1, AXI_ID_BITS'($urandom), rand_addr(2), 4'd2);
			end
		join
		wait_drain("outstanding");
		bp_mode = 1'b0;
		end_test("outstanding", e0);

		if (stuck_s0 || stuck_s1) begin
			errors++;
			$display("A slave model never saw its beats accepted");
		end
		$display("Tests run %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb_mem_slave.sv
`default_nettype none

module tb_mem_slave #(
	parameter int                DATA_W = axi_bus_pkg::AXI_DATA_BITS,
	parameter logic [DATA_W-1:0] KEY    = '0
) (
	input  wire                                  ACLK,
	input  wire                                  ARESETn,
	input  wire  [axi_bus_pkg::AXI_IDS_BITS-1:0]  arid,
	input  wire  [axi_bus_pkg::AXI_ADDR_BITS-1:0] araddr,
	input  wire  [axi_bus_pkg::AXI_LEN_BITS-1:0]  arlen,
	input  wire                                  arvalid,
	output logic                                 arready,
	output logic [axi_bus_pkg::AXI_IDS_BITS-1:0]  rid,
	output logic [DATA_W-1:0]                    rdata,
	output logic [1:0]                           rresp,
	output logic                                 rlast,
	output logic                                 rvalid,
	input  wire                                  rready,
	output logic                                 stuck
);

	import axi_bus_pkg::*;

	logic [AXI_ADDR_BITS-1:0] addr_q;
	logic [AXI_LEN_BITS-1:0]  len_q;
	int                       wait_cnt;
	int                       delay;

	// Serves one burst at a time, inputs sampled just after the falling edge
	initial begin
		arready = 1'b0;
		rid     = '0;
		rdata   = '0;
		rresp   = '0;
		rlast   = 1'b0;
		rvalid  = 1'b0;
		stuck   = 1'b0;
		forever begin
			@(negedge ACLK);
			#1;
			if (ARESETn && arvalid) begin
				rid    = arid;
				addr_q = araddr;
				len_q  = arlen;
				// Address accepted after 0 to 3 idle cycles
				delay = int'($urandom_range(3, 0));
				repeat (delay + 1) @(negedge ACLK);
				arready = 1'b1;
				@(negedge ACLK);
				arready = 1'b0;
				for (int k = 0; k <= int'(len_q); k++) begin
					delay = int'($urandom_range(2, 0));
					repeat (delay) @(negedge ACLK);
					rdata  = DATA_W'(addr_q + AXI_ADDR_BITS'(4 * k)) ^ KEY;
					rresp  = OKAY;
					rlast  = (k == int'(len_q));
					rvalid = 1'b1;
					wait_cnt = 0;
					#1;
					while (!rready && wait_cnt < 1000) begin
						@(negedge ACLK);
						#1;
						wait_cnt++;
					end
					if (!rready) begin
						stuck = 1'b1;
						$display("Slave model gave up waiting for rready at time %0t", $time);
					end
					@(negedge ACLK);
					rvalid = 1'b0;
					rlast  = 1'b0;
					if (stuck) begin
						break;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire
